// File: compile.f
+incdir+include
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/issue_queue.sv
hw/exec_unit.sv
hw/decode_core_top.sv
testbench/tb_decode_core.sv

// File: hw/decode_core_top.sv
// Decode and issue core top level

`timescale 1ns/1ps

module decode_core_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_valid_i,
  input  decode_pkg::fetch_pkt_t fetch_pkt_i,
  output logic                   fetch_ready_o,
  output logic                   retire_valid_o,
  output decode_pkg::retire_t    retire_o,
  input  logic                   retire_ready_i
);

  logic                  push;
  decode_pkg::issue_op_t push_op;
  logic                  credit;
  logic                  head_valid;
  decode_pkg::issue_op_t head_op;
  logic                  pop;

  instr_decoder decoder_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pkt_i   (fetch_pkt_i),
    .fetch_ready_o (fetch_ready_o),
    .credit_i      (credit),
    .push_o        (push),
    .push_op_o     (push_op)
  );

  issue_queue queue_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_op_i    (push_op),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_op_o    (head_op),
    .credit_o     (credit)
  );

  exec_unit exec_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .head_valid_i   (head_valid),
    .head_op_i      (head_op),
    .pop_o          (pop),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .retire_ready_i (retire_ready_i)
  );

endmodule

// File: hw/decode_pkg.sv
// Decode core shared definitions

package decode_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int unsigned XLEN     = 32;
  localparam int unsigned NUM_REGS = 32;
  localparam int unsigned IQ_DEPTH = 4;
  localparam int unsigned IQ_PTR_W = 2;
  // Must hold 0 to IQ_DEPTH inclusive
  localparam int unsigned CREDIT_W = 3;

  // RV32I major opcodes kept by this core
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OP_IMM = 7'h13;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_AUIPC  = 7'h17;

  ////////////////////
  // Vector types
  ////////////////////

  typedef logic [XLEN-1:0]     word_t;
  typedef logic [4:0]          reg_addr_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  ////////////////////
  // ALU control
  ////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  ////////////////////
  // Packets
  ////////////////////

  // Instruction word with its program counter
  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_pkt_t;

  // One decoded operation as held in the issue queue
  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      we;
    logic      illegal;
    word_t     imm;
    word_t     pc;
  } issue_op_t;

  // Result of one operation leaving the core
  typedef struct packed {
    reg_addr_t rd;
    word_t     wdata;
    logic      we;
    logic      illegal;
    word_t     pc;
  } retire_t;

endpackage

// File: hw/exec_unit.sv
// Execute unit with register file and ALU

`timescale 1ns/1ps

module exec_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  head_valid_i,
  input  decode_pkg::issue_op_t head_op_i,
  output logic                  pop_o,
  output logic                  retire_valid_o,
  output decode_pkg::retire_t   retire_o,
  input  logic                  retire_ready_i
);

  decode_pkg::word_t rf_q [decode_pkg::NUM_REGS];
  decode_pkg::word_t rdata_a;
  decode_pkg::word_t rdata_b;
  decode_pkg::word_t operand_a;
  decode_pkg::word_t operand_b;
  decode_pkg::word_t alu_result;
  logic [4:0]        shamt;
  logic              rf_we;

  ////////////////////
  // Operands
  ////////////////////

  // x0 is never written so it reads zero
  assign rdata_a = rf_q[head_op_i.rs1];
  assign rdata_b = rf_q[head_op_i.rs2];

  always_comb begin
    unique case (head_op_i.op_a_sel)
      decode_pkg::OP_A_REG_A:  operand_a = rdata_a;
      decode_pkg::OP_A_CURRPC: operand_a = head_op_i.pc;
      default:                 operand_a = '0;
    endcase
  end

  assign operand_b = (head_op_i.op_b_sel == decode_pkg::OP_B_IMM) ? head_op_i.imm : rdata_b;
  assign shamt     = operand_b[4:0];

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    unique case (head_op_i.alu_op)
      decode_pkg::ALU_ADD:  alu_result = operand_a + operand_b;
      decode_pkg::ALU_SUB:  alu_result = operand_a - operand_b;
      decode_pkg::ALU_XOR:  alu_result = operand_a ^ operand_b;
      decode_pkg::ALU_OR:   alu_result = operand_a | operand_b;
      decode_pkg::ALU_AND:  alu_result = operand_a & operand_b;
      decode_pkg::ALU_SLL:  alu_result = operand_a << shamt;
      decode_pkg::ALU_SRL:  alu_result = operand_a >> shamt;
      decode_pkg::ALU_SRA:  alu_result = $unsigned($signed(operand_a) >>> shamt);
      decode_pkg::ALU_SLT: begin
        alu_result = {{(decode_pkg::XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
      end
      decode_pkg::ALU_SLTU: begin
        alu_result = {{(decode_pkg::XLEN-1){1'b0}}, operand_a < operand_b};
      end
      default:              alu_result = '0;
    endcase
  end

  ////////////////////
  // Retire and writeback
  ////////////////////

  assign retire_valid_o = head_valid_i;
  assign pop_o          = head_valid_i & retire_ready_i;

  // Writes to x0 retire with we set but are not stored
  assign rf_we = pop_o & head_op_i.we & (head_op_i.rd != '0);

  always_comb begin
    retire_o.rd      = head_op_i.rd;
    retire_o.wdata   = alu_result;
    retire_o.we      = head_op_i.we;
    retire_o.illegal = head_op_i.illegal;
    retire_o.pc      = head_op_i.pc;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rf_q <= '{default: '0};
    end else if (rf_we) begin
      rf_q[head_op_i.rd] <= alu_result;
    end
  end

  // x0 holds zero across every retire
  x0_zero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_q[0] == '0)
    else $error("Register x0 storage was written");

endmodule

// File: hw/instr_decoder.sv
// Instruction decoder with credit counter

`timescale 1ns/1ps

module instr_decoder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_valid_i,
  input  decode_pkg::fetch_pkt_t fetch_pkt_i,
  output logic                   fetch_ready_o,
  input  logic                   credit_i,
  output logic                   push_o,
  output decode_pkg::issue_op_t  push_op_o
);

  decode_pkg::word_t   instr;
  decode_pkg::word_t   imm_i_type;
  decode_pkg::word_t   imm_u_type;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                illegal;
  decode_pkg::credit_t credit_q;

  assign instr  = fetch_pkt_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // Sign extended I-type, upper U-type
  assign imm_i_type = {{20{instr[31]}}, instr[31:20]};
  assign imm_u_type = {instr[31:12], 12'b0};

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    push_op_o.alu_op   = decode_pkg::ALU_ADD;
    push_op_o.op_a_sel = decode_pkg::OP_A_REG_A;
    push_op_o.op_b_sel = decode_pkg::OP_B_REG_B;
    push_op_o.imm      = imm_i_type;
    illegal            = 1'b0;

    unique case (opcode)
      decode_pkg::OPCODE_OP: begin
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: push_op_o.alu_op = decode_pkg::ALU_ADD;
          {7'h20, 3'b000}: push_op_o.alu_op = decode_pkg::ALU_SUB;
          {7'h00, 3'b001}: push_op_o.alu_op = decode_pkg::ALU_SLL;
          {7'h00, 3'b010}: push_op_o.alu_op = decode_pkg::ALU_SLT;
          {7'h00, 3'b011}: push_op_o.alu_op = decode_pkg::ALU_SLTU;
          {7'h00, 3'b100}: push_op_o.alu_op = decode_pkg::ALU_XOR;
          {7'h00, 3'b101}: push_op_o.alu_op = decode_pkg::ALU_SRL;
          {7'h20, 3'b101}: push_op_o.alu_op = decode_pkg::ALU_SRA;
          {7'h00, 3'b110}: push_op_o.alu_op = decode_pkg::ALU_OR;
          {7'h00, 3'b111}: push_op_o.alu_op = decode_pkg::ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      decode_pkg::OPCODE_OP_IMM: begin
        push_op_o.op_b_sel = decode_pkg::OP_B_IMM;
        unique case (funct3)
          3'b000: push_op_o.alu_op = decode_pkg::ALU_ADD;
          3'b010: push_op_o.alu_op = decode_pkg::ALU_SLT;
          3'b011: push_op_o.alu_op = decode_pkg::ALU_SLTU;
          3'b100: push_op_o.alu_op = decode_pkg::ALU_XOR;
          3'b110: push_op_o.alu_op = decode_pkg::ALU_OR;
          3'b111: push_op_o.alu_op = decode_pkg::ALU_AND;
          3'b001: begin
            push_op_o.alu_op = decode_pkg::ALU_SLL;
            illegal          = (funct7 != 7'h00);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            if (funct7 == 7'h00) begin
              push_op_o.alu_op = decode_pkg::ALU_SRL;
            end else if (funct7 == 7'h20) begin
              push_op_o.alu_op = decode_pkg::ALU_SRA;
            end else begin
              illegal = 1'b1;
            end
          end
        endcase
      end
      decode_pkg::OPCODE_LUI: begin
        push_op_o.op_a_sel = decode_pkg::OP_A_ZERO;
        push_op_o.op_b_sel = decode_pkg::OP_B_IMM;
        push_op_o.imm      = imm_u_type;
      end
      decode_pkg::OPCODE_AUIPC: begin
        push_op_o.op_a_sel = decode_pkg::OP_A_CURRPC;
        push_op_o.op_b_sel = decode_pkg::OP_B_IMM;
        push_op_o.imm      = imm_u_type;
      end
      default: illegal = 1'b1;
    endcase

    // Illegal words retire a zero result
    if (illegal) begin
      push_op_o.alu_op   = decode_pkg::ALU_ADD;
      push_op_o.op_a_sel = decode_pkg::OP_A_ZERO;
      push_op_o.op_b_sel = decode_pkg::OP_B_IMM;
      push_op_o.imm      = '0;
    end

    push_op_o.rs1     = instr[19:15];
    push_op_o.rs2     = instr[24:20];
    push_op_o.rd      = instr[11:7];
    push_op_o.we      = ~illegal;
    push_op_o.illegal = illegal;
    push_op_o.pc      = fetch_pkt_i.pc;
  end

  ////////////////////
  // Credits
  ////////////////////

  assign fetch_ready_o = (credit_q != '0);
  assign push_o        = fetch_valid_i & fetch_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= decode_pkg::credit_t'(decode_pkg::IQ_DEPTH);
    end else if (push_o && !credit_i) begin
      credit_q <= credit_q - 1'b1;
    end else if (!push_o && credit_i) begin
      credit_q <= credit_q + 1'b1;
    end
  end

  // Returned credits never outnumber the queue slots
  credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= decode_pkg::IQ_DEPTH)
    else $error("Credit count above queue depth");

  fetch_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i |-> !$isunknown(fetch_pkt_i))
    else $error("Fetch packet has unknown bits while valid");

endmodule

// File: hw/issue_queue.sv
// Issue queue for decoded operations

`timescale 1ns/1ps

module issue_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  decode_pkg::issue_op_t push_op_i,
  input  logic                  pop_i,
  output logic                  head_valid_o,
  output decode_pkg::issue_op_t head_op_o,
  output logic                  credit_o
);

  decode_pkg::issue_op_t           slots_q [decode_pkg::IQ_DEPTH];
  logic [decode_pkg::IQ_PTR_W-1:0] wr_ptr_q;
  logic [decode_pkg::IQ_PTR_W-1:0] rd_ptr_q;
  logic [decode_pkg::IQ_PTR_W:0]   count_q;
  logic                            credit_q;

  // Slot storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      slots_q[wr_ptr_q] <= push_op_i;
    end
  end

  ////////////////////
  // Pointers
  ////////////////////

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // One credit back per freed slot, a cycle late
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_i;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_op_o    = slots_q[rd_ptr_q];
  assign credit_o     = credit_q;

  // Decoder credits must keep pushes away from a full queue
  no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q != decode_pkg::IQ_DEPTH))
    else $error("Push into full issue queue");

  no_pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (count_q != '0))
    else $error("Pop from empty issue queue");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_decode_core \
  -Mdir obj_dir \
  -o sim_decode_core

./obj_dir/sim_decode_core | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: include/tb_ref_model.svh
// Decode core reference model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ALU result by funct3, alt selects SUB or SRA
function automatic decode_pkg::word_t ref_alu(
  input logic [2:0]        funct3,
  input logic              alt,
  input decode_pkg::word_t a,
  input decode_pkg::word_t b
);
  case (funct3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return decode_pkg::word_t'($signed(a) < $signed(b));
    3'b011: return decode_pkg::word_t'(a < b);
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) begin
        return $unsigned($signed(a) >>> b[4:0]);
      end
      return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

// Expected retire record for one packet, model x0 must hold zero
function automatic decode_pkg::retire_t ref_model_exec(
  input decode_pkg::fetch_pkt_t pkt,
  input decode_pkg::word_t      rf [decode_pkg::NUM_REGS]
);
  decode_pkg::retire_t res;
  decode_pkg::word_t   instr;
  decode_pkg::word_t   src_a;
  decode_pkg::word_t   imm_i;
  logic [6:0]          funct7;
  logic [2:0]          funct3;
  logic                alt_ok;
  instr  = pkt.instr;
  funct7 = instr[31:25];
  funct3 = instr[14:12];
  src_a  = rf[instr[19:15]];
  imm_i  = {{20{instr[31]}}, instr[31:20]};
  alt_ok = (funct7 == 7'h20) && (funct3 == 3'b000 || funct3 == 3'b101);
  res.rd      = instr[11:7];
  res.pc      = pkt.pc;
  res.we      = 1'b1;
  res.illegal = 1'b0;
  res.wdata   = '0;
  case (instr[6:0])
    decode_pkg::OPCODE_OP: begin
      if (funct7 == 7'h00 || alt_ok) begin
        res.wdata = ref_alu(funct3, funct7[5], src_a, rf[instr[24:20]]);
      end else begin
        res.illegal = 1'b1;
      end
    end
    decode_pkg::OPCODE_OP_IMM: begin
      if (funct3 != 3'b001 && funct3 != 3'b101) begin
        res.wdata = ref_alu(funct3, 1'b0, src_a, imm_i);
      end else if (funct7 == 7'h00 || (alt_ok && funct3 == 3'b101)) begin
        res.wdata = ref_alu(funct3, funct7[5], src_a, imm_i);
      end else begin
        res.illegal = 1'b1;
      end
    end
    decode_pkg::OPCODE_LUI:   res.wdata = {instr[31:12], 12'b0};
    decode_pkg::OPCODE_AUIPC: res.wdata = pkt.pc + {instr[31:12], 12'b0};
    default:                  res.illegal = 1'b1;
  endcase
  if (res.illegal) begin
    res.we    = 1'b0;
    res.wdata = '0;
  end
  return res;
endfunction

`endif

// File: testbench/tb_decode_core.sv
// Decode core testbench

`timescale 1ns/1ps

module tb_decode_core;

  `include "tb_ref_model.svh"

  localparam int CLK_PERIOD_NS = 100;
  localparam int N_RANDOM      = 200;
  // Upper bound on packets sent by all phases
  localparam int N_INSTR       = N_RANDOM + 60;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   fetch_valid_i;
  decode_pkg::fetch_pkt_t fetch_pkt_i;
  logic                   fetch_ready_o;
  logic                   retire_valid_o;
  decode_pkg::retire_t    retire_o;
  logic                   retire_ready_i;

  decode_pkg::fetch_pkt_t pending_q [$];
  decode_pkg::word_t      model_rf [decode_pkg::NUM_REGS] = '{default: '0};
  decode_pkg::word_t      next_pc = 32'h0000_1000;
  integer                 seed = 32'hf028;
  int                     error_count = 0;
  int                     check_count = 0;
  int                     accept_count = 0;
  int                     retire_count = 0;
  logic                   random_ready = 1'b0;

  // funct7 and funct3 of the ten register-register operations
  logic [6:0] r_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                            7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
  logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};

  decode_core_top decode_core_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_pkt_i    (fetch_pkt_i),
    .fetch_ready_o  (fetch_ready_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .retire_ready_i (retire_ready_i)
  );

  always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

  ////////////////////
  // Encoders
  ////////////////////

  function automatic decode_pkg::word_t enc_r(input logic [6:0] f7, input decode_pkg::reg_addr_t rs2,
      input decode_pkg::reg_addr_t rs1, input logic [2:0] f3, input decode_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, decode_pkg::OPCODE_OP};
  endfunction

  function automatic decode_pkg::word_t enc_i(input logic [11:0] imm,
      input decode_pkg::reg_addr_t rs1, input logic [2:0] f3, input decode_pkg::reg_addr_t rd);
    return {imm, rs1, f3, rd, decode_pkg::OPCODE_OP_IMM};
  endfunction

  function automatic decode_pkg::word_t enc_u(input logic [19:0] imm,
      input decode_pkg::reg_addr_t rd, input logic [6:0] opcode);
    return {imm, rd, opcode};
  endfunction

  // Weighted mix of legal kinds plus mostly illegal words
  function automatic decode_pkg::word_t random_instr();
    decode_pkg::word_t r;
    int                kind;
    int                k;
    logic [11:0]       imm;
    r    = $random(seed);
    kind = {$random(seed)} % 10;
    k    = {$random(seed)} % 10;
    imm  = r[31:20];
    if (r[14:12] == 3'b001) imm = {7'h00, r[24:20]};
    if (r[14:12] == 3'b101) imm = {(r[30] ? 7'h20 : 7'h00), r[24:20]};
    case (kind)
      0, 1, 2: return enc_r(r_f7[k], r[24:20], r[19:15], r_f3[k], r[11:7]);
      3, 4, 5: return enc_i(imm, r[19:15], r[14:12], r[11:7]);
      6:       return enc_u(r[31:12], r[11:7], decode_pkg::OPCODE_LUI);
      7:       return enc_u(r[31:12], r[11:7], decode_pkg::OPCODE_AUIPC);
      8:       return $random(seed);
      default: return enc_r(r[31:25], r[24:20], r[19:15], r[14:12], r[11:7]);
    endcase
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic compare_retire(input decode_pkg::retire_t actual,
                                input decode_pkg::retire_t expected);
    check_count++;
    if (actual.rd !== expected.rd) begin
      error_count++;
      $display("FAIL retire_o.rd pc %h: got %h, expected %h", expected.pc, actual.rd, expected.rd);
    end
    if (actual.wdata !== expected.wdata) begin
      error_count++;
      $display("FAIL retire_o.wdata pc %h: got %h, expected %h",
               expected.pc, actual.wdata, expected.wdata);
    end
    if (actual.we !== expected.we) begin
      error_count++;
      $display("FAIL retire_o.we pc %h: got %h, expected %h", expected.pc, actual.we, expected.we);
    end
    if (actual.illegal !== expected.illegal) begin
      error_count++;
      $display("FAIL retire_o.illegal pc %h: got %h, expected %h",
               expected.pc, actual.illegal, expected.illegal);
    end
    if (actual.pc !== expected.pc) begin
      error_count++;
      $display("FAIL retire_o.pc: got %h, expected %h", actual.pc, expected.pc);
    end
  endtask

  task automatic compare_bit(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  // Scoreboard, retire checked before the same edge's acceptance
  always @(posedge clk_i) begin : scoreboard
    decode_pkg::fetch_pkt_t pkt;
    decode_pkg::retire_t    expected;
    if (rst_ni) begin
      if (retire_valid_o && retire_ready_i) begin
        if (pending_q.size() == 0) begin
          error_count++;
          $display("ERROR: a retire happened with no accepted packet outstanding");
        end else begin
          pkt      = pending_q.pop_front();
          expected = ref_model_exec(pkt, model_rf);
          compare_retire(retire_o, expected);
          if (expected.we && expected.rd != '0) model_rf[expected.rd] = expected.wdata;
          retire_count++;
        end
      end
      if (fetch_valid_i && fetch_ready_o) begin
        pending_q.push_back(fetch_pkt_i);
        accept_count++;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic issue_instr(input decode_pkg::word_t instr);
    fetch_valid_i     = 1'b1;
    fetch_pkt_i.instr = instr;
    fetch_pkt_i.pc    = next_pc;
    if (random_ready) retire_ready_i = ($random(seed) & 32'h3) != 0;
    while (!fetch_ready_o) begin
      @(negedge clk_i);
      if (random_ready) retire_ready_i = ($random(seed) & 32'h3) != 0;
    end
    @(negedge clk_i);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic wait_drain();
    fetch_valid_i  = 1'b0;
    random_ready   = 1'b0;
    retire_ready_i = 1'b1;
    while (pending_q.size() != 0) @(negedge clk_i);
  endtask

  initial begin : watchdog
    #((N_INSTR * 20 + 10) * CLK_PERIOD_NS);
    $display("ERROR: watchdog timeout, the run did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rst_ni         = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_pkt_i    = '0;
    retire_ready_i = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare_bit("fetch_ready_o", fetch_ready_o, 1'b1);
    compare_bit("retire_valid_o", retire_valid_o, 1'b0);

    // Back-pressure, queue fills and fetch stalls
    for (int k = 0; k < decode_pkg::IQ_DEPTH; k++) begin
      issue_instr(enc_i(12'(16 * k + 3), 5'd0, 3'b000, 5'(k + 1)));
    end
    fetch_valid_i     = 1'b1;
    fetch_pkt_i.instr = enc_i(12'h055, 5'd1, 3'b000, 5'd5);
    repeat (3) begin
      compare_bit("fetch_ready_o", fetch_ready_o, 1'b0);
      compare_bit("retire_valid_o", retire_valid_o, 1'b1);
      @(negedge clk_i);
    end
    if (accept_count != decode_pkg::IQ_DEPTH) begin
      error_count++;
      $display("ERROR: %0d packets accepted while retire stalled, queue holds %0d",
               accept_count, decode_pkg::IQ_DEPTH);
    end
    retire_ready_i = 1'b1;
    issue_instr(enc_i(12'h055, 5'd1, 3'b000, 5'd5));
    wait_drain();

    // Single cycle retire from an empty queue
    compare_bit("retire_valid_o", retire_valid_o, 1'b0);
    issue_instr(enc_i(12'h7ff, 5'd5, 3'b100, 5'd6));
    fetch_valid_i = 1'b0;
    compare_bit("retire_valid_o", retire_valid_o, 1'b1);
    wait_drain();

    // Directed ALU, immediate, x0 and illegal cases
    issue_instr(enc_u(20'h80000, 5'd1, decode_pkg::OPCODE_LUI));
    issue_instr(enc_i(12'h123, 5'd1, 3'b000, 5'd1));
    issue_instr(enc_i(12'hffb, 5'd0, 3'b000, 5'd2));
    issue_instr(enc_i(12'h007, 5'd0, 3'b000, 5'd3));
    for (int k = 0; k < 10; k++) issue_instr(enc_r(r_f7[k], 5'd3, 5'd1, r_f3[k], 5'(k + 4)));
    for (int k = 0; k < 10; k++) issue_instr(enc_r(r_f7[k], 5'd1, 5'd2, r_f3[k], 5'd14));
    for (int k = 0; k < 8; k++) begin
      issue_instr(enc_i((k == 1 || k == 5) ? 12'h009 : 12'h8f0, 5'd1, 3'(k), 5'd15));
    end
    issue_instr(enc_i(12'h409, 5'd1, 3'b101, 5'd16));
    issue_instr(enc_u(20'h12345, 5'd17, decode_pkg::OPCODE_AUIPC));
    issue_instr(enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd0));
    issue_instr(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd18));
    issue_instr(32'h0000_0000);
    issue_instr(32'hffff_ffff);
    issue_instr(enc_r(7'h01, 5'd3, 5'd1, 3'b000, 5'd1));
    issue_instr({12'h000, 5'd1, 3'b010, 5'd1, 7'h03});
    issue_instr(enc_i(12'h409, 5'd1, 3'b001, 5'd1));
    issue_instr(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd20));
    wait_drain();

    // Random mix with random retire stalls
    random_ready = 1'b1;
    repeat (N_RANDOM) issue_instr(random_instr());
    wait_drain();
    repeat (2) @(negedge clk_i);

    if (retire_count != accept_count) begin
      error_count++;
      $display("ERROR: %0d packets accepted but %0d retired", accept_count, retire_count);
    end
    $display("Checks %0d, errors %0d, accepted %0d, retired %0d",
             check_count, error_count, accept_count, retire_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
